// File: core_ctrl.sv
/*
 * core controller top
 * exception detector, interrupt selector and controller FSM
 */

`timescale 1ns/1ps

module core_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_enable_i,
  input  ctrl_pkg::fetch_t           fetch_i,
  input  ctrl_pkg::decode_t          decode_i,
  input  ctrl_pkg::lsu_err_t         lsu_err_i,
  input  ctrl_pkg::irq_in_t          irq_i,
  input  logic                       stall_id_i,
  input  logic                       branch_set_i,
  input  logic                       jump_set_i,
  input  riscv_arch_pkg::priv_lvl_e  priv_mode_i,
  input  logic                       mstatus_tw_i,
  output ctrl_pkg::pc_ctrl_t         pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t        csr_ctrl_o,
  output logic                       id_in_ready_o,
  output logic                       instr_valid_clear_o,
  output logic                       flush_id_o,
  output logic                       instr_req_o,
  output logic                       ctrl_busy_o,
  output logic                       controller_run_o,
  output logic                       nmi_mode_o
);
  import ctrl_pkg::*;

  exc_req_t                   exc_req;
  ctrl_state_e                state;
  logic                       irq_take;
  riscv_arch_pkg::exc_cause_e irq_cause;

  // synchronous exceptions, one cycle behind decode
  exc_prio u_exc_prio (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .decode_i     (decode_i),
    .fetch_i      (fetch_i),
    .lsu_err_i    (lsu_err_i),
    .priv_mode_i  (priv_mode_i),
    .mstatus_tw_i (mstatus_tw_i),
    .state_i      (state),
    .exc_req_o    (exc_req)
  );

  // NMI mode from the FSM masks everything
  irq_select u_irq_select (
    .irq_i       (irq_i),
    .nmi_mode_i  (nmi_mode_o),
    .irq_take_o  (irq_take),
    .irq_cause_o (irq_cause)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .stall_id_i          (stall_id_i),
    .instr_valid_i       (fetch_i.valid),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .irq_pending_i       (irq_i.pending),
    .irq_nm_i            (irq_i.nm),
    .exc_req_i           (exc_req),
    .irq_take_i          (irq_take),
    .irq_cause_i         (irq_cause),
    .state_o             (state),
    .pc_ctrl_o           (pc_ctrl_o),
    .csr_ctrl_o          (csr_ctrl_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .instr_req_o         (instr_req_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .nmi_mode_o          (nmi_mode_o)
  );

endmodule

// File: ctrl_defines.svh
/*
 * core controller parameters
 * widths shared by the packages and the controller blocks
 */

`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// datapath width, covers pc, instruction word and mtval
`define XLEN 32

// number of fast interrupt lines from the CSR block
`define NUM_FAST_IRQ 15

// width of the mcause code, msb flags an interrupt
`define CAUSE_W 6

// width of the controller state encoding
`define CTRL_STATE_W 4

`endif

// File: ctrl_fsm.sv
/*
 * controller state machine
 * boot, decode, flush, sleep and interrupt entry, with NMI mode
 * and the stall and flush controls of the IF-ID register
 */

`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  input  logic                        stall_id_i,
  input  logic                        instr_valid_i,
  input  logic                        branch_set_i,
  input  logic                        jump_set_i,
  input  logic                        irq_pending_i,
  input  logic                        irq_nm_i,
  input  ctrl_pkg::exc_req_t          exc_req_i,
  input  logic                        irq_take_i,
  input  riscv_arch_pkg::exc_cause_e  irq_cause_i,
  output ctrl_pkg::ctrl_state_e       state_o,
  output ctrl_pkg::pc_ctrl_t          pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t         csr_ctrl_o,
  output logic                        id_in_ready_o,
  output logic                        instr_valid_clear_o,
  output logic                        flush_id_o,
  output logic                        instr_req_o,
  output logic                        ctrl_busy_o,
  output logic                        controller_run_o,
  output logic                        nmi_mode_o
);
  import ctrl_pkg::*;
  import riscv_arch_pkg::*;

  ctrl_state_e state_q, state_d;
  logic nmi_mode_q, nmi_mode_d;
  logic halt_if, retain_id, flush_id;
  logic special_req;

  // any flag that forces the instruction through FLUSH
  assign special_req = exc_req_i.req_pc | exc_req_i.flush_only;

  ////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    nmi_mode_d = nmi_mode_q;

    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;

    // mux values only matter while pc_set is high
    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_mux     = PC_BOOT;
    pc_ctrl_o.exc_pc_mux = EXC_PC_IRQ;

    csr_ctrl_o.save_if      = 1'b0;
    csr_ctrl_o.save_id      = 1'b0;
    csr_ctrl_o.restore_mret = 1'b0;
    csr_ctrl_o.save_cause   = 1'b0;
    csr_ctrl_o.cause        = EXC_CAUSE_INSN_ADDR_MISA;
    csr_ctrl_o.mtval        = '0;

    unique case (state_q)
      RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o      = 1'b0;
        pc_ctrl_o.pc_set = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        // one cycle to let the pipeline drain
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending interrupt, even with mie clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to enter ID
        if (id_in_ready_o) begin
          state_d = DECODE;
        end
        if (irq_take_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_ctrl_o.pc_mux = PC_JUMP;

        // keep the instruction in ID for FLUSH to inspect
        if (special_req) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        if (branch_set_i || jump_set_i) begin
          pc_ctrl_o.pc_set = 1'b1;
        end

        // interrupts wait for the instruction in ID to finish
        if (irq_take_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end
        if (irq_take_i && !stall_id_i && !special_req && !instr_valid_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_ctrl_o.pc_mux     = PC_EXC;
        pc_ctrl_o.exc_pc_mux = EXC_PC_IRQ;
        if (irq_take_i) begin
          pc_ctrl_o.pc_set      = 1'b1;
          csr_ctrl_o.save_if    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = irq_cause_i;
          // enter NMI mode
          if (irq_cause_i == EXC_CAUSE_IRQ_NM) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (exc_req_i.taken) begin
          // trap, mepc takes the pc of the instruction in ID
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = PC_EXC;
          pc_ctrl_o.exc_pc_mux  = EXC_PC_EXC;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = exc_req_i.cause;
          csr_ctrl_o.mtval      = exc_req_i.mtval;
        end else if (exc_req_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_mux        = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
          // leaving the NMI handler
          nmi_mode_d              = 1'b0;
        end else if (exc_req_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // stall control
  ////////////////////////////////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain keeps valid set unless the entry is flushed anyway
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;

  assign state_o    = state_q;
  assign nmi_mode_o = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// File: ctrl_pkg.sv
/*
 * controller types
 * pc selectors, FSM states and the bundles between controller,
 * IF-ID stage, LSU and CSRs
 */

`include "ctrl_defines.svh"

package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////
  // selectors and states
  ////////////////////////////////////////////////////////////////////

  // fetch address source in the IF stage
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // trap vector, only meaningful with PC_EXC
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////

  // decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_flush;
  } decode_t;

  // IF-ID register contents
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  instr;
    logic [15:0]       instr_c;
    logic              is_c;
    logic              fetch_err;
    logic              fetch_err_plus2;
    logic [`XLEN-1:0]  pc;
  } fetch_t;

  // LSU error pulse plus the faulting address
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic             load_err;
    logic             store_err;
  } lsu_err_t;

  // interrupt state from the CSRs
  typedef struct packed {
    riscv_arch_pkg::irqs_t irqs;
    logic                  nm;
    logic                  pending;
    logic                  mie;
  } irq_in_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  typedef struct packed {
    logic                       save_if;
    logic                       save_id;
    logic                       restore_mret;
    logic                       save_cause;
    riscv_arch_pkg::exc_cause_e cause;
    logic [`XLEN-1:0]           mtval;
  } csr_ctrl_t;

  // exception detector to FSM
  typedef struct packed {
    logic                       req_pc;
    logic                       flush_only;
    logic                       taken;
    logic                       mret;
    logic                       wfi;
    riscv_arch_pkg::exc_cause_e cause;
    logic [`XLEN-1:0]           mtval;
  } exc_req_t;

endpackage

// File: exc_prio.sv
/*
 * exception detector
 * qualifies decoder flags, registers the requests and picks the
 * winning synchronous exception with its cause and mtval
 */

`timescale 1ns/1ps

`include "ctrl_defines.svh"

module exc_prio (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  ctrl_pkg::decode_t           decode_i,
  input  ctrl_pkg::fetch_t            fetch_i,
  input  ctrl_pkg::lsu_err_t          lsu_err_i,
  input  riscv_arch_pkg::priv_lvl_e   priv_mode_i,
  input  logic                        mstatus_tw_i,
  input  ctrl_pkg::ctrl_state_e       state_i,
  output ctrl_pkg::exc_req_t          exc_req_o
);
  import ctrl_pkg::*;
  import riscv_arch_pkg::*;

  logic ecall, mret, wfi, ebrk, csr_flush, fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_d, exc_q;
  logic load_err_q, store_err_q;
  logic not_flush;
  logic [`XLEN-1:0] lsu_addr_q;
  logic [`XLEN-1:0] pc_plus2;

  // decoder ignores valid, fold it in here
  assign ecall     = decode_i.ecall     & fetch_i.valid;
  assign mret      = decode_i.mret      & fetch_i.valid;
  assign wfi       = decode_i.wfi       & fetch_i.valid;
  assign ebrk      = decode_i.ebrk      & fetch_i.valid;
  assign csr_flush = decode_i.csr_flush & fetch_i.valid;
  assign fetch_err = fetch_i.fetch_err  & fetch_i.valid;

  // mret needs M-mode, TW traps wfi out of U-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & (mret | (mstatus_tw_i & wfi));

  // requests drop in FLUSH so a handled trap does not repeat
  assign not_flush = (state_i != FLUSH);
  assign illegal_d = ((decode_i.illegal & fetch_i.valid) | illegal_umode) & not_flush;
  assign exc_d     = (ecall | ebrk | illegal_d | fetch_err) & not_flush;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_q       <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_q       <= exc_d;
      load_err_q  <= lsu_err_i.load_err & not_flush;
      store_err_q <= lsu_err_i.store_err & not_flush;
    end
  end

  // faulting address, sampled alongside the error pulse
  always_ff @(posedge clk_i) begin
    lsu_addr_q <= lsu_err_i.addr;
  end

  // second half of a misaligned fetch faulted
  assign pc_plus2 = fetch_i.pc + `XLEN'd2;

  // pc changing requests, lsu errors arrive without a valid instruction
  assign exc_req_o.req_pc     = mret | exc_d | lsu_err_i.load_err | lsu_err_i.store_err;
  assign exc_req_o.flush_only = wfi | csr_flush;
  assign exc_req_o.taken      = exc_q | load_err_q | store_err_q;
  assign exc_req_o.mret       = mret;
  assign exc_req_o.wfi        = wfi;

  // privileged spec order
  // fetch fault, illegal, ecall, ebreak, store fault, load fault
  always_comb begin
    exc_req_o.cause = EXC_CAUSE_INSN_ADDR_MISA;
    exc_req_o.mtval = '0;
    if (fetch_err) begin
      exc_req_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      exc_req_o.mtval = fetch_i.fetch_err_plus2 ? pc_plus2 : fetch_i.pc;
    end else if (illegal_q) begin
      exc_req_o.cause = EXC_CAUSE_ILLEGAL_INSN;
      exc_req_o.mtval = fetch_i.is_c ? {{(`XLEN-16){1'b0}}, fetch_i.instr_c} : fetch_i.instr;
    end else if (ecall) begin
      exc_req_o.cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                      EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk) begin
      // no debug mode, ebreak always traps
      exc_req_o.cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_req_o.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      exc_req_o.mtval = lsu_addr_q;
    end else if (load_err_q) begin
      exc_req_o.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      exc_req_o.mtval = lsu_addr_q;
    end
  end

endmodule

// File: irq_select.sv
/*
 * interrupt selector
 * decides whether an interrupt is taken and encodes its cause
 */

`timescale 1ns/1ps

`include "ctrl_defines.svh"

module irq_select (
  input  ctrl_pkg::irq_in_t           irq_i,
  input  logic                        nmi_mode_i,
  output logic                        irq_take_o,
  output riscv_arch_pkg::exc_cause_e  irq_cause_o
);
  import riscv_arch_pkg::*;

  // fast line id fills the cause below the two marker bits
  localparam int unsigned FAST_ID_W = `CAUSE_W - 2;

  logic [FAST_ID_W-1:0] mfip_id;

  // the NMI handler is never interrupted since nested NMIs are not supported
  assign irq_take_o = ~nmi_mode_i & (irq_i.nm | (irq_i.pending & irq_i.mie));

  // lowest numbered fast line wins
  always_comb begin
    mfip_id = '0;
    for (int i = `NUM_FAST_IRQ - 1; i >= 0; i--) begin
      if (irq_i.irqs.irq_fast[i]) begin
        mfip_id = i[FAST_ID_W-1:0];
      end
    end
  end

  // NMI, fast, external, software, timer
  always_comb begin
    if (irq_i.nm) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (irq_i.irqs.irq_fast != '0) begin
      irq_cause_o = exc_cause_e'({2'b11, mfip_id});
    end else if (irq_i.irqs.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_i.irqs.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      // only timer left
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

// File: riscv_arch_pkg.sv
/*
 * RISC-V architectural types
 * privilege levels, trap cause codes and the interrupt vector
 */

`include "ctrl_defines.svh"

package riscv_arch_pkg;

  // privilege mode, only M and U are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mcause encoding
  // msb set for interrupts, fast line n maps to {2'b11, n}
  typedef enum logic [`CAUSE_W-1:0] {
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_FAST_0         = {1'b1, 5'd16},
    EXC_CAUSE_IRQ_FAST_14        = {1'b1, 5'd30},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31},
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 5'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_LOAD_ACCESS_FAULT  = {1'b0, 5'd5},
    EXC_CAUSE_STORE_ACCESS_FAULT = {1'b0, 5'd7},
    EXC_CAUSE_ECALL_UMODE        = {1'b0, 5'd8},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11}
  } exc_cause_e;

  // interrupt requests already qualified with mie
  typedef struct packed {
    logic                     irq_software;
    logic                     irq_timer;
    logic                     irq_external;
    logic [`NUM_FAST_IRQ-1:0] irq_fast;
  } irqs_t;

endpackage

// File: tb.f
+incdir+.
riscv_arch_pkg.sv
ctrl_pkg.sv
exc_prio.sv
irq_select.sv
ctrl_fsm.sv
core_ctrl.sv
tb_core_ctrl.sv

// File: tb_core_ctrl.sv
/*
 * core controller testbench
 * boot, exceptions, priority, interrupts, NMI, WFI and jumps,
 * checked against a reference model of the trap rules
 */

`timescale 1ns/1ps

`include "ctrl_defines.svh"

module tb_core_ctrl;
  import ctrl_pkg::*;
  import riscv_arch_pkg::*;

  localparam int NUM_TESTS = 30;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic fetch_enable_i;
  fetch_t fetch_i;
  decode_t decode_i;
  lsu_err_t lsu_err_i;
  irq_in_t irq_i;
  logic stall_id_i, branch_set_i, jump_set_i;
  priv_lvl_e priv_mode_i;
  logic mstatus_tw_i;
  pc_ctrl_t pc_ctrl_o;
  csr_ctrl_t csr_ctrl_o;
  logic id_in_ready_o, instr_valid_clear_o, flush_id_o;
  logic instr_req_o, ctrl_busy_o, controller_run_o, nmi_mode_o;

  // bookkeeping
  string cur_name = "reset";
  int err_count = 0;
  int errs_at_start = 0;
  int n_tests = 0;
  int n_pass = 0;
  int n_fail = 0;
  int vec_hits = 0;
  pc_ctrl_t exp_pc;
  csr_ctrl_t exp_csr;

  core_ctrl uut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  // fetch fault ranks above illegal, ecall, ebreak, store and load
  function automatic csr_ctrl_t ref_csr(input decode_t d, input fetch_t f,
                                        input lsu_err_t l, input priv_lvl_e p,
                                        input logic tw, input irq_in_t q,
                                        input logic irq_path);
    csr_ctrl_t r;
    logic v;
    logic ill;
    int n;
    r = '0;
    r.save_cause = 1'b1;
    if (irq_path) begin
      r.save_if = 1'b1;
      if (q.nm) begin
        r.cause = EXC_CAUSE_IRQ_NM;
      end else if (q.irqs.irq_fast != '0) begin
        n = 0;
        while (!q.irqs.irq_fast[n]) n++;
        r.cause = exc_cause_e'({2'b11, n[3:0]});
      end else if (q.irqs.irq_external) begin
        r.cause = EXC_CAUSE_IRQ_EXTERNAL_M;
      end else if (q.irqs.irq_software) begin
        r.cause = EXC_CAUSE_IRQ_SOFTWARE_M;
      end else begin
        r.cause = EXC_CAUSE_IRQ_TIMER_M;
      end
      return r;
    end
    r.save_id = 1'b1;
    v = f.valid;
    // mret outside M, or wfi trapped by TW, is illegal
    ill = v & (d.illegal | ((p != PRIV_LVL_M) & (d.mret | (tw & d.wfi))));
    if (v && f.fetch_err) begin
      r.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      r.mtval = f.fetch_err_plus2 ? f.pc + 32'd2 : f.pc;
    end else if (ill) begin
      r.cause = EXC_CAUSE_ILLEGAL_INSN;
      r.mtval = f.is_c ? {{(`XLEN-16){1'b0}}, f.instr_c} : f.instr;
    end else if (v && d.ecall) begin
      r.cause = (p == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (v && d.ebrk) begin
      r.cause = EXC_CAUSE_BREAKPOINT;
    end else if (l.store_err) begin
      r.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      r.mtval = l.addr;
    end else if (l.load_err) begin
      r.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      r.mtval = l.addr;
    end
    return r;
  endfunction

  function automatic pc_ctrl_t mk_pc(input pc_sel_e m, input exc_pc_sel_e e);
    pc_ctrl_t r;
    r.pc_set     = 1'b1;
    r.pc_mux     = m;
    r.exc_pc_mux = e;
    return r;
  endfunction

  // valid instruction with random contents and no flags
  function automatic fetch_t rand_fetch();
    fetch_t f;
    f         = '0;
    f.valid   = 1'b1;
    f.instr   = $urandom;
    f.instr_c = $urandom;
    f.pc      = $urandom & 32'hffff_fffe;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////

  // vector select only counts for the trap vector
  task automatic compare_pc(input string name, input pc_ctrl_t e, input pc_ctrl_t a);
    if (e.pc_set !== a.pc_set || e.pc_mux !== a.pc_mux ||
        (e.pc_mux == PC_EXC && e.exc_pc_mux !== a.exc_pc_mux)) begin
      $display("Fail %s: pc_ctrl expected %h actual %h", name, e, a);
      err_count++;
    end
  endtask

  // cause and mtval only count when saved
  task automatic compare_csr(input string name, input csr_ctrl_t e, input csr_ctrl_t a);
    if (e.save_if !== a.save_if || e.save_id !== a.save_id ||
        e.restore_mret !== a.restore_mret || e.save_cause !== a.save_cause ||
        (e.save_cause && (e.cause !== a.cause || e.mtval !== a.mtval))) begin
      $display("Fail %s: csr_ctrl expected %h actual %h", name, e, a);
      err_count++;
    end
  endtask

  task automatic expect_bit(input string what, input logic e, input logic a);
    if (e !== a) begin
      $display("Fail %s: %s expected %0b actual %0b", cur_name, what, e, a);
      err_count++;
    end
  endtask

  task automatic complain(input string msg);
    $display("Error in %s: %s", cur_name, msg);
    err_count++;
  endtask

  task automatic start_test(input string name);
    cur_name      = name;
    errs_at_start = err_count;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_count == errs_at_start) begin
      n_pass++;
      $display("test %s: ok", cur_name);
    end else begin
      n_fail++;
      $display("test %s: failed", cur_name);
    end
  endtask

  task automatic idle_inputs();
    fetch_i      = '0;
    decode_i     = '0;
    lsu_err_i    = '0;
    priv_mode_i  = PRIV_LVL_M;
    mstatus_tw_i = 1'b0;
    stall_id_i   = 1'b0;
    branch_set_i = 1'b0;
    jump_set_i   = 1'b0;
  endtask

  // every trap or interrupt vector is checked here
  always @(posedge clk_i) begin
    if (rst_ni && pc_ctrl_o.pc_set && pc_ctrl_o.pc_mux == PC_EXC) begin
      compare_pc(cur_name, exp_pc, pc_ctrl_o);
      compare_csr(cur_name, exp_csr, csr_ctrl_o);
      vec_hits++;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////////////

  // the trap follows in FLUSH one cycle after the decode cycle
  task automatic run_exc(input string name, input decode_t d, input fetch_t f,
                         input lsu_err_t l, input priv_lvl_e p, input logic tw);
    int base;
    start_test(name);
    exp_pc  = mk_pc(PC_EXC, EXC_PC_EXC);
    exp_csr = ref_csr(d, f, l, p, tw, irq_i, 1'b0);
    base    = vec_hits;
    @(negedge clk_i);
    decode_i     = d;
    fetch_i      = f;
    lsu_err_i    = l;
    priv_mode_i  = p;
    mstatus_tw_i = tw;
    @(negedge clk_i);
    // lsu error is a single cycle pulse
    lsu_err_i.load_err  = 1'b0;
    lsu_err_i.store_err = 1'b0;
    if (vec_hits != base) complain("trap vector taken in the decode cycle");
    @(negedge clk_i);
    if (vec_hits != base + 1) complain("trap vector missing in the FLUSH cycle");
    idle_inputs();
    end_test();
  endtask

  task automatic run_irq(input string name, input irq_in_t q);
    int base;
    start_test(name);
    exp_pc  = mk_pc(PC_EXC, EXC_PC_IRQ);
    exp_csr = ref_csr(decode_i, fetch_i, lsu_err_i, priv_mode_i, 1'b0, q, 1'b1);
    base    = vec_hits;
    @(negedge clk_i);
    irq_i = q;
    @(negedge clk_i);
    if (vec_hits != base) complain("interrupt vector taken too early");
    @(negedge clk_i);
    if (vec_hits != base + 1) complain("interrupt vector missing in IRQ_TAKEN");
    irq_i = '0;
    end_test();
  endtask

  initial begin
    decode_t d;
    fetch_t f;
    lsu_err_t l;
    irq_in_t q;
    csr_ctrl_t c;
    priv_lvl_e p;
    logic tw;
    int n;
    int base;

    void'($urandom(32'h55b2_d76f));
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    irq_i          = '0;
    idle_inputs();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // boot sequence
    start_test("boot");
    @(negedge clk_i);
    compare_pc(cur_name, mk_pc(PC_BOOT, EXC_PC_EXC), pc_ctrl_o);
    compare_csr(cur_name, '0, csr_ctrl_o);
    expect_bit("instr_req_o in RESET", 1'b0, instr_req_o);
    expect_bit("controller_run_o in RESET", 1'b0, controller_run_o);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    compare_pc(cur_name, mk_pc(PC_BOOT, EXC_PC_EXC), pc_ctrl_o);
    expect_bit("instr_req_o in BOOT_SET", 1'b1, instr_req_o);
    n = 0;
    while (!controller_run_o && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    if (!controller_run_o) complain("controller_run_o never rose after boot");
    end_test();

    // single exceptions
    d = '0;
    l = '0;
    f = rand_fetch();
    f.fetch_err       = 1'b1;
    f.fetch_err_plus2 = 1'b1;
    run_exc("fetch_err_plus2", d, f, l, PRIV_LVL_M, 1'b0);
    f = rand_fetch();
    f.is_c    = 1'b1;
    d.illegal = 1'b1;
    run_exc("illegal_compressed", d, f, l, PRIV_LVL_M, 1'b0);
    f = rand_fetch();
    run_exc("illegal_full", d, f, l, PRIV_LVL_M, 1'b0);
    d = '0;
    d.mret = 1'b1;
    f = rand_fetch();
    run_exc("mret_umode", d, f, l, PRIV_LVL_U, 1'b0);
    d = '0;
    d.ecall = 1'b1;
    run_exc("ecall_mmode", d, f, l, PRIV_LVL_M, 1'b0);
    run_exc("ecall_umode", d, f, l, PRIV_LVL_U, 1'b0);
    d = '0;
    d.ebrk = 1'b1;
    run_exc("ebreak", d, f, l, PRIV_LVL_M, 1'b0);
    d = '0;
    f = '0;
    l.addr     = $urandom;
    l.load_err = 1'b1;
    run_exc("load_fault", d, f, l, PRIV_LVL_M, 1'b0);
    l.addr      = $urandom;
    l.load_err  = 1'b0;
    l.store_err = 1'b1;
    run_exc("store_fault", d, f, l, PRIV_LVL_M, 1'b0);
    l = '0;
    d.wfi = 1'b1;
    f = rand_fetch();
    run_exc("wfi_tw_umode", d, f, l, PRIV_LVL_U, 1'b1);

    // simultaneous flags
    for (int i = 0; i < 8; i++) begin
      d = decode_t'($urandom);
      f = rand_fetch();
      f.fetch_err       = $urandom;
      f.fetch_err_plus2 = $urandom;
      f.is_c            = $urandom;
      l.addr      = $urandom;
      l.load_err  = $urandom;
      l.store_err = $urandom;
      p  = ($urandom % 2) ? PRIV_LVL_M : PRIV_LVL_U;
      tw = $urandom;
      if (!(f.fetch_err | d.illegal | d.ecall | d.ebrk | l.load_err | l.store_err |
            ((p != PRIV_LVL_M) & (d.mret | (tw & d.wfi))))) begin
        d.ecall = 1'b1;
      end
      run_exc($sformatf("priority_%0d", i), d, f, l, p, tw);
    end

    // random interrupts where even runs raise a single fast line
    for (int i = 0; i < 6; i++) begin
      q = '0;
      q.irqs = irqs_t'($urandom);
      if (i % 2 == 0) q.irqs.irq_fast = 15'd1 << ($urandom % `NUM_FAST_IRQ);
      if (q.irqs == '0) q.irqs.irq_timer = 1'b1;
      q.pending = 1'b1;
      q.mie     = 1'b1;
      run_irq($sformatf("irq_%0d", i), q);
    end

    // NMI, masking in NMI mode, exit by mret
    q = '0;
    q.nm = 1'b1;
    run_irq("nmi", q);
    start_test("nmi_mret");
    expect_bit("nmi_mode_o after NMI", 1'b1, nmi_mode_o);
    base = vec_hits;
    irq_i.pending        = 1'b1;
    irq_i.mie            = 1'b1;
    irq_i.irqs.irq_timer = 1'b1;
    repeat (3) @(negedge clk_i);
    if (vec_hits != base) complain("interrupt taken while in NMI mode");
    irq_i = '0;
    fetch_i = rand_fetch();
    decode_i.mret = 1'b1;
    @(negedge clk_i);
    c = '0;
    c.restore_mret = 1'b1;
    compare_pc(cur_name, mk_pc(PC_ERET, EXC_PC_EXC), pc_ctrl_o);
    compare_csr(cur_name, c, csr_ctrl_o);
    @(negedge clk_i);
    idle_inputs();
    expect_bit("nmi_mode_o after mret", 1'b0, nmi_mode_o);
    end_test();

    // WFI sleep and wake up
    start_test("wfi_sleep");
    fetch_i = rand_fetch();
    decode_i.wfi = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    expect_bit("ctrl_busy_o in WAIT_SLEEP", 1'b0, ctrl_busy_o);
    expect_bit("flush_id_o in WAIT_SLEEP", 1'b1, flush_id_o);
    idle_inputs();
    repeat (2) begin
      @(negedge clk_i);
      expect_bit("ctrl_busy_o in SLEEP", 1'b0, ctrl_busy_o);
      expect_bit("flush_id_o in SLEEP", 1'b1, flush_id_o);
    end
    irq_i.pending           = 1'b1;
    irq_i.irqs.irq_external = 1'b1;
    #1;
    expect_bit("ctrl_busy_o on wake", 1'b1, ctrl_busy_o);
    n = 0;
    while (!controller_run_o && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    if (!controller_run_o) complain("core never returned to DECODE after wake up");
    irq_i = '0;
    end_test();

    // branch and jump redirect in the same cycle
    start_test("branch_jump");
    @(negedge clk_i);
    branch_set_i = 1'b1;
    #1 compare_pc(cur_name, mk_pc(PC_JUMP, EXC_PC_EXC), pc_ctrl_o);
    expect_bit("flush_id_o in DECODE", 1'b0, flush_id_o);
    @(negedge clk_i);
    branch_set_i = 1'b0;
    jump_set_i   = 1'b1;
    #1 compare_pc(cur_name, mk_pc(PC_JUMP, EXC_PC_EXC), pc_ctrl_o);
    @(negedge clk_i);
    idle_inputs();
    end_test();

    // stall holds the instruction in ID
    start_test("stall_jump");
    stall_id_i = 1'b1;
    jump_set_i = 1'b1;
    fetch_i    = rand_fetch();
    repeat (3) begin
      #1;
      compare_pc(cur_name, mk_pc(PC_JUMP, EXC_PC_EXC), pc_ctrl_o);
      expect_bit("instr_valid_clear_o under stall", 1'b0, instr_valid_clear_o);
      expect_bit("id_in_ready_o under stall", 1'b0, id_in_ready_o);
      @(negedge clk_i);
    end
    stall_id_i = 1'b0;
    jump_set_i = 1'b0;
    #1 expect_bit("instr_valid_clear_o after stall", 1'b1, instr_valid_clear_o);
    @(negedge clk_i);
    idle_inputs();
    end_test();

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_pass, n_fail, err_count);
    if (n_fail == 0 && err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog allows about 50 cycles per test
  initial begin
    repeat (16 + NUM_TESTS * 50) @(posedge clk_i);
    $display("Error: watchdog expired in %s, the run did not finish", cur_name);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
